//--- verilog/alloc_macros.svh
// allocator self-test sizing constants shared by RTL and testbench

`ifndef ALLOC_MACROS_SVH
`define ALLOC_MACROS_SVH

// cell pool, address 0 is the nil link and never handed out
`define ALLOC_CELLS   64

// cell address width, must cover ALLOC_CELLS - 1
`define ALLOC_ADDR_W  6

// payload word stored in each cell
`define ALLOC_DATA_W  16

// settle cycles between reset release and test start
`define START_DELAY   64

// number of rows in the built-in test script
`define SCRIPT_LEN    12

`endif

//--- verilog/alloc_pkg.sv
// allocator types: opcodes, FSM states, request/response words, debug selector

`default_nettype none

`include "alloc_macros.svh"

package alloc_pkg;

    typedef enum logic [1:0] {
        op_alloc = 2'd0,  // take a cell, store data
        op_free  = 2'd1,  // return a cell to the free list
        op_read  = 2'd2   // fetch a cell's data
    } alloc_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_pop,    // link read from list head
        st_write,  // data into popped cell
        st_link,   // old head into freed cell
        st_read    // wait for read data
    } alloc_state_e;

    typedef enum logic [1:0] {
        ts_wait,   // start-up delay
        ts_issue,
        ts_check,
        ts_done
    } test_state_e;

    typedef enum logic [1:0] {
        dbg_step,
        dbg_in_use,
        dbg_last_addr,
        dbg_errors
    } debug_sel_e;

    typedef struct packed {
        alloc_op_e                 op;
        logic [`ALLOC_ADDR_W-1:0]  addr;  // free/read target
        logic [`ALLOC_DATA_W-1:0]  data;  // alloc payload
    } alloc_req_t;

    typedef struct packed {
        logic [`ALLOC_ADDR_W-1:0]  addr;
        logic [`ALLOC_DATA_W-1:0]  data;
        logic                      fail;  // alloc found no cell
    } alloc_rsp_t;

endpackage

`default_nettype wire

//--- verilog/cell_mem.sv
// single-port cell RAM, synchronous write and registered read

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module cell_mem (
    input  wire logic                      clk,
    input  wire logic [`ALLOC_ADDR_W-1:0]  addr,
    input  wire logic [`ALLOC_DATA_W-1:0]  wdata,
    input  wire logic                      we,
    output logic      [`ALLOC_DATA_W-1:0]  rdata
);

    // maps onto block RAM
    logic [`ALLOC_DATA_W-1:0] mem [0:`ALLOC_CELLS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // read-first, old contents on a write
    end

endmodule

`default_nettype wire

//--- verilog/alloc_pool.sv
// free-list allocator, reuses freed cells (LIFO) before handing out fresh ones

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module alloc_pool (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    req_valid,
    input  wire alloc_pkg::alloc_req_t   req,
    output logic                         done,
    output alloc_pkg::alloc_rsp_t        rsp,
    output logic [`ALLOC_ADDR_W:0]       in_use
);

    alloc_pkg::alloc_state_e    state;
    logic [`ALLOC_ADDR_W-1:0]   head;       // free list head, 0 = empty
    logic [`ALLOC_ADDR_W:0]     fresh;      // next never-used cell
    logic [`ALLOC_ADDR_W-1:0]   cur_addr;   // cell of the op in flight
    logic [`ALLOC_DATA_W-1:0]   cur_data;
    logic [`ALLOC_ADDR_W-1:0]   mem_addr;
    logic [`ALLOC_DATA_W-1:0]   mem_wdata;
    logic [`ALLOC_DATA_W-1:0]   mem_rdata;
    logic                       mem_we;
    logic                       list_empty;
    logic                       fresh_full;

    assign list_empty = (head == '0);
    assign fresh_full = (fresh == (`ALLOC_ADDR_W+1)'(`ALLOC_CELLS));  // pool exhausted

    cell_mem cells0 (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    // memory port steering
    always_comb begin
        mem_addr  = cur_addr;
        mem_wdata = cur_data;
        mem_we    = 1'b0;
        case (state)
            alloc_pkg::st_idle: begin
                if (req_valid) begin
                    mem_wdata = req.data;
                    if (req.op == alloc_pkg::op_alloc) begin
                        // head read for a pop, or direct write of a fresh cell
                        mem_addr = list_empty ? fresh[`ALLOC_ADDR_W-1:0] : head;
                        mem_we   = list_empty && !fresh_full;
                    end else begin
                        mem_addr = req.addr;
                    end
                end
            end
            alloc_pkg::st_write: mem_we = 1'b1;
            alloc_pkg::st_link: begin
                mem_wdata = `ALLOC_DATA_W'(head);  // link to previous head
                mem_we    = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= alloc_pkg::st_idle;
            head   <= '0;
            fresh  <= (`ALLOC_ADDR_W+1)'(1);  // address 0 is nil
            in_use <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                alloc_pkg::st_idle: begin
                    if (req_valid) begin
                        case (req.op)
                            alloc_pkg::op_alloc: begin
                                if (!list_empty) begin
                                    state <= alloc_pkg::st_pop;
                                end else begin
                                    done <= 1'b1;  // fresh cell, written this cycle
                                    if (!fresh_full) begin
                                        fresh  <= fresh + 1'b1;
                                        in_use <= in_use + 1'b1;
                                    end
                                end
                            end
                            alloc_pkg::op_free: state <= alloc_pkg::st_link;
                            alloc_pkg::op_read: state <= alloc_pkg::st_read;
                            default:            done  <= 1'b1;  // bad opcode answers as fail
                        endcase
                    end
                end
                alloc_pkg::st_pop: begin
                    head  <= mem_rdata[`ALLOC_ADDR_W-1:0];
                    state <= alloc_pkg::st_write;
                end
                alloc_pkg::st_write: begin
                    in_use <= in_use + 1'b1;
                    done   <= 1'b1;
                    state  <= alloc_pkg::st_idle;
                end
                alloc_pkg::st_link: begin
                    head   <= cur_addr;  // freed cell becomes the head
                    in_use <= in_use - 1'b1;
                    done   <= 1'b1;
                    state  <= alloc_pkg::st_idle;
                end
                alloc_pkg::st_read: begin
                    done  <= 1'b1;
                    state <= alloc_pkg::st_idle;
                end
                default: state <= alloc_pkg::st_idle;
            endcase
        end
    end

    // operation payload and response word
    always_ff @(posedge clk) begin
        case (state)
            alloc_pkg::st_idle: begin
                if (req_valid) begin
                    cur_addr <= (req.op == alloc_pkg::op_alloc) ? head : req.addr;
                    cur_data <= req.data;
                    // final only for a fresh alloc or a bad opcode
                    rsp.addr <= fresh_full ? '0 : fresh[`ALLOC_ADDR_W-1:0];
                    rsp.data <= req.data;
                    rsp.fail <= fresh_full || (req.op != alloc_pkg::op_alloc);
                end
            end
            alloc_pkg::st_write: rsp <= '{addr: cur_addr, data: cur_data, fail: 1'b0};
            alloc_pkg::st_link:  rsp <= '{addr: cur_addr, data: '0, fail: 1'b0};
            alloc_pkg::st_read:  rsp <= '{addr: cur_addr, data: mem_rdata, fail: 1'b0};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/alloc_test.sv
// scripted allocator test, issues each step, checks the answer, counts errors

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module alloc_test (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    en,
    output logic                         req_valid,
    output alloc_pkg::alloc_req_t        req,
    input  wire logic                    done,
    input  wire alloc_pkg::alloc_rsp_t   rsp,
    output logic                         running,
    output logic                         passed,
    output logic [3:0]                   step,
    output logic [`ALLOC_ADDR_W-1:0]     last_addr,
    output logic [3:0]                   errors
);

    localparam logic [`ALLOC_DATA_W-1:0] DATA_BASE = 16'hA000;

    typedef struct packed {
        alloc_pkg::alloc_req_t  req;
        alloc_pkg::alloc_rsp_t  rsp;  // expected answer
    } row_t;

    // data of step n is DATA_BASE + n, step 0 means no data
    function automatic row_t mk_row(
        input alloc_pkg::alloc_op_e  op,
        input int unsigned           addr,
        input int unsigned           dstep,
        input int unsigned           exp_addr,
        input int unsigned           exp_dstep
    );
        row_t r;
        r.req.op   = op;
        r.req.addr = `ALLOC_ADDR_W'(addr);
        r.req.data = (dstep == 0) ? '0 : DATA_BASE + `ALLOC_DATA_W'(dstep);
        r.rsp.addr = `ALLOC_ADDR_W'(exp_addr);
        r.rsp.data = (exp_dstep == 0) ? '0 : DATA_BASE + `ALLOC_DATA_W'(exp_dstep);
        r.rsp.fail = 1'b0;
        return r;
    endfunction

    function automatic row_t script_row(input logic [3:0] idx);
        row_t r;
        case (idx)
            4'd1:    r = mk_row(alloc_pkg::op_alloc, 0, 1, 1, 1);
            4'd2:    r = mk_row(alloc_pkg::op_alloc, 0, 2, 2, 2);
            4'd3:    r = mk_row(alloc_pkg::op_alloc, 0, 3, 3, 3);
            4'd4:    r = mk_row(alloc_pkg::op_free, 2, 0, 2, 0);
            4'd5:    r = mk_row(alloc_pkg::op_alloc, 0, 5, 2, 5);   // reuses cell 2
            4'd6:    r = mk_row(alloc_pkg::op_read, 1, 0, 1, 1);
            4'd7:    r = mk_row(alloc_pkg::op_read, 2, 0, 2, 5);
            4'd8:    r = mk_row(alloc_pkg::op_read, 3, 0, 3, 3);
            4'd9:    r = mk_row(alloc_pkg::op_free, 1, 0, 1, 0);
            4'd10:   r = mk_row(alloc_pkg::op_free, 2, 0, 2, 0);
            4'd11:   r = mk_row(alloc_pkg::op_free, 3, 0, 3, 0);
            4'd12:   r = mk_row(alloc_pkg::op_alloc, 0, 12, 3, 12); // last freed comes back
            default: r = '0;
        endcase
        return r;
    endfunction

    alloc_pkg::test_state_e  state;
    row_t                    row;
    logic                    mismatch;
    logic [3:0]              errors_next;

    always_comb begin
        row = script_row(step);
    end

    assign req         = row.req;  // held steady until done
    assign mismatch    = (rsp != row.rsp);
    assign errors_next = (mismatch && errors != 4'hF) ? errors + 1'b1 : errors;  // saturating

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= alloc_pkg::ts_wait;
            req_valid <= 1'b0;
            running   <= 1'b0;
            passed    <= 1'b0;
            step      <= '0;
            last_addr <= '0;
            errors    <= '0;
        end else begin
            req_valid <= 1'b0;  // strobe lasts one cycle
            case (state)
                alloc_pkg::ts_wait: begin
                    if (en) begin
                        running <= 1'b1;
                        step    <= 4'd1;
                        state   <= alloc_pkg::ts_issue;
                    end
                end
                alloc_pkg::ts_issue: begin
                    req_valid <= 1'b1;
                    state     <= alloc_pkg::ts_check;
                end
                alloc_pkg::ts_check: begin
                    if (done) begin
                        errors    <= errors_next;
                        last_addr <= rsp.addr;
                        if (step == 4'(`SCRIPT_LEN)) begin
                            running <= 1'b0;
                            passed  <= (errors_next == '0);
                            state   <= alloc_pkg::ts_done;
                        end else begin
                            step  <= step + 1'b1;
                            state <= alloc_pkg::ts_issue;
                        end
                    end
                end
                alloc_pkg::ts_done: state <= alloc_pkg::ts_done;  // results held until reset
                default:            state <= alloc_pkg::ts_wait;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/selftest_top.sv
// allocator self-test top: start-up delay, debug word mux, LED levels

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module selftest_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire alloc_pkg::debug_sel_e  dbg_sel,
    output logic [15:0]                 debug,
    output logic                        led_r,
    output logic                        led_g,
    output logic                        led_b
);

    localparam int DELAY_W = $clog2(`START_DELAY) + 1;

    logic [DELAY_W-1:0]         delay_cnt;
    logic                       en;
    logic                       req_valid;
    alloc_pkg::alloc_req_t      req;
    logic                       done;
    alloc_pkg::alloc_rsp_t      rsp;
    logic [`ALLOC_ADDR_W:0]     in_use;
    logic                       running;
    logic                       passed;
    logic [3:0]                 step;
    logic [`ALLOC_ADDR_W-1:0]   last_addr;
    logic [3:0]                 errors;

    // let the RAM settle before the script starts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            delay_cnt <= '0;
        end else if (!en) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    assign en = (delay_cnt == DELAY_W'(`START_DELAY));  // stays high once reached

    alloc_test test0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (en),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp),
        .running   (running),
        .passed    (passed),
        .step      (step),
        .last_addr (last_addr),
        .errors    (errors)
    );

    alloc_pool pool0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp),
        .in_use    (in_use)
    );

    always_comb begin
        case (dbg_sel)
            alloc_pkg::dbg_step:      debug = 16'(step);
            alloc_pkg::dbg_in_use:    debug = 16'(in_use);
            alloc_pkg::dbg_last_addr: debug = 16'(last_addr);
            alloc_pkg::dbg_errors:    debug = 16'(errors);
            default:                  debug = '0;
        endcase
    end

    assign led_b = running;
    assign led_g = passed;
    assign led_r = !passed;  // red until a clean run completes

endmodule

`default_nettype wire

//--- testbench/selftest_props.sv
// allocator self-test properties, bound into the self-test top level

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module selftest_props (
    input wire logic                   clk,
    input wire logic                   arst_n,
    input wire logic                   done,
    input wire logic [`ALLOC_ADDR_W:0] in_use,
    input wire logic                   running,
    input wire logic                   passed,
    input wire logic                   led_r,
    input wire logic                   led_g
);

    int fail_count = 0;  // assertion failures so far

    // done is a strobe
    done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $error("done high for two consecutive cycles");
            fail_count++;
        end

    // cell 0 is nil, so at most ALLOC_CELLS-1 in use
    in_use_bound: assert property (@(posedge clk) disable iff (!arst_n)
        in_use <= (`ALLOC_ADDR_W+1)'(`ALLOC_CELLS - 1))
        else begin
            $error("in_use %0d above pool size", in_use);
            fail_count++;
        end

    passed_held: assert property (@(posedge clk) disable iff (!arst_n)
        (!running && $past(!running)) |-> $stable(passed))
        else begin
            $error("passed changed while no run was active");
            fail_count++;
        end

    leds_compl: assert property (@(posedge clk) disable iff (!arst_n) led_r != led_g)
        else begin
            $error("led_r and led_g not complementary");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- testbench/tb_selftest.sv
// testbench for the allocator self-test top checking LED levels, debug word and rerun

`timescale 1ns/1ps
`default_nettype none

`include "alloc_macros.svh"

module tb_selftest;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } leds_t;

    typedef struct packed {
        alloc_pkg::debug_sel_e  sel;
        logic [15:0]            value;
    } dbg_row_t;

    localparam leds_t LEDS_IDLE = '{r: 1'b1, g: 1'b0, b: 1'b0};
    localparam leds_t LEDS_PASS = '{r: 1'b0, g: 1'b1, b: 1'b0};

    logic                   clk = 1'b0;
    logic                   arst_n = 1'b0;
    alloc_pkg::debug_sel_e  dbg_sel = alloc_pkg::dbg_step;
    logic [15:0]            debug;
    logic                   led_r;
    logic                   led_g;
    logic                   led_b;

    logic [31:0]  lfsr = 32'h1740;
    dbg_row_t     rows [4];
    string        row_names [4];
    int           checks = 0;
    int           errors = 0;
    int           tests = 0;
    int           failed_tests = 0;
    int           test_err0 = 0;
    bit           timed_out = 1'b0;

    always #4 clk = ~clk;  // 8 ns period

    selftest_top dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .dbg_sel (dbg_sel),
        .debug   (debug),
        .led_r   (led_r),
        .led_g   (led_g),
        .led_b   (led_b)
    );

    bind selftest_top selftest_props props0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .done    (done),
        .in_use  (in_use),
        .running (running),
        .passed  (passed),
        .led_r   (led_r),
        .led_g   (led_g)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic tick(input int unsigned n = 1);
        repeat (n) @(posedge clk);
        #1;  // drive and sample just after the edge
    endtask

    function automatic leds_t leds_now();
        return '{r: led_r, g: led_g, b: led_b};
    endfunction

    task automatic end_test(input string name);
        tests++;
        if (errors != test_err0) begin
            failed_tests++;
            $display("test %-18s FAILED", name);
        end else begin
            $display("test %-18s ok", name);
        end
        test_err0 = errors;
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_leds(input string name, input leds_t exp, input leds_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected rgb %b, actual rgb %b", name, exp, act);
        end
    endtask

    task automatic wait_led_b(input logic level, input string what);
        int n;
        n = 0;
        while (led_b !== level && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (led_b !== level) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: led_b did not %s within %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic reset_phase(input string tag);
        arst_n = 1'b0;
        tick();
        check_leds({"reset_", tag}, LEDS_IDLE, leds_now());
        tick();
        arst_n = 1'b1;
        for (int i = 0; i < `START_DELAY / 2; i++) begin  // still settling
            tick();
            check_leds({"delay_", tag}, LEDS_IDLE, leds_now());
        end
        end_test({"reset_", tag});
    endtask

    task automatic run_phase(input string tag);
        wait_led_b(1'b1, "rise");
        if (!timed_out) begin
            wait_led_b(1'b0, "fall");
        end
        if (!timed_out) begin
            check_leds({"run_", tag}, LEDS_PASS, leds_now());
        end
        end_test({"run_", tag});
    endtask

    task automatic debug_phase(input string tag);
        int unsigned order [4];
        int unsigned j;
        int unsigned tmp;
        int unsigned idle;
        for (int i = 0; i < 4; i++) begin
            order[i] = i;
        end
        for (int i = 3; i > 0; i--) begin  // shuffle
            draw_bits(2, j);
            j = j % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < 4; k++) begin
            draw_bits(3, idle);
            if (idle != 0) begin
                tick(idle);
            end
            dbg_sel = rows[order[k]].sel;
            tick();
            check_word({row_names[order[k]], "_", tag}, rows[order[k]].value, debug);
            end_test({row_names[order[k]], "_", tag});
        end
    endtask

    task automatic sweep_phase();
        int unsigned s;
        for (int k = 0; k < 8; k++) begin
            draw_bits(2, s);
            dbg_sel = alloc_pkg::debug_sel_e'(s);
            tick();
            check_leds("sel_sweep", LEDS_PASS, leds_now());
        end
        end_test("sel_sweep");
    endtask

    task automatic run_all();
        reset_phase("first");
        run_phase("first");
        if (timed_out) begin
            return;
        end
        debug_phase("first");
        sweep_phase();
        reset_phase("rerun");
        run_phase("rerun");
        if (timed_out) begin
            return;
        end
        debug_phase("rerun");
    endtask

    initial begin
        rows[0] = '{sel: alloc_pkg::dbg_step, value: 16'd12};       // script length
        rows[1] = '{sel: alloc_pkg::dbg_in_use, value: 16'd1};      // all freed, one taken back
        rows[2] = '{sel: alloc_pkg::dbg_last_addr, value: 16'd3};   // LIFO head after step 11
        rows[3] = '{sel: alloc_pkg::dbg_errors, value: 16'd0};
        row_names[0] = "dbg_step";
        row_names[1] = "dbg_in_use";
        row_names[2] = "dbg_last_addr";
        row_names[3] = "dbg_errors";
        run_all();
        if (dut0.props0.fail_count != 0) begin
            $display("%0d assertion failures", dut0.props0.fail_count);
            errors += dut0.props0.fail_count;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/alloc_pkg.sv
verilog/cell_mem.sv
verilog/alloc_pool.sv
verilog/alloc_test.sv
verilog/selftest_top.sv
testbench/selftest_props.sv
testbench/tb_selftest.sv

//--- Bender.yml
package:
  name: alloc_selftest

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/alloc_pkg.sv
      - verilog/cell_mem.sv
      - verilog/alloc_pool.sv
      - verilog/alloc_test.sv
      - verilog/selftest_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/selftest_props.sv
      - testbench/tb_selftest.sv
